/* logic/coreDefs.sv */
`default_nettype none

package coreDefs;

	typedef enum logic [1:0] {
		stFetch,
		stExec,
		stMem,
		stWb
	} seqStateT;

	// RV32I base opcodes handled by the core
	typedef enum logic [6:0] {
		opLui    = 7'b0110111,
		opAuipc  = 7'b0010111,
		opJal    = 7'b1101111,
		opJalr   = 7'b1100111,
		opBranch = 7'b1100011,
		opLoad   = 7'b0000011,
		opStore  = 7'b0100011,
		opImm    = 7'b0010011,
		opReg    = 7'b0110011
	} rvOpcodeT;

	typedef enum logic [4:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluXor,
		aluSlt, aluSltu, aluSll, aluSrl, aluSra,
		aluPassB,
		aluEq, aluNe, aluLt, aluGe, aluLtu, aluGeu
	} aluOpT;

	typedef enum logic {srcReg, srcPc} srcASelT;

	typedef enum logic [1:0] {wbAlu, wbMem, wbLink} wbSelT;

	typedef enum logic [1:0] {pcStep, pcBranch, pcJal, pcJalr} pcSelT;

	typedef struct packed {
		logic    regWrite;
		logic    memRead;
		logic    memWrite;
		logic    aluSrcImm;
		logic    illegal;
		srcASelT srcA;
		aluOpT   aluOp;
		wbSelT   wbSel;
		pcSelT   pcSel;
	} ctrlT;

	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] wdata;
		logic        re;
		logic        we;
	} memReqT;

	// One entry per retired instruction
	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		logic [31:0] instr;
		logic        rdWrite;
		logic [4:0]  rdAddr;
		logic [31:0] rdData;
		logic [31:0] nextPc;
	} traceT;

endpackage

`default_nettype wire

/* logic/instrDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instrDecoder import coreDefs::*; (
	input  logic [31:0] instr,
	output ctrlT        ctrl,
	output logic [31:0] imm
);

	logic [6:0]  opcode;
	logic [2:0]  funct3;
	logic [6:0]  funct7;
	logic [31:0] immI;
	logic [31:0] immS;
	logic [31:0] immB;
	logic [31:0] immU;
	logic [31:0] immJ;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	assign immI = {{20{instr[31]}}, instr[31:20]};
	assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign immU = {instr[31:12], 12'b0};
	assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		ctrl = '0;
		ctrl.srcA = srcReg;
		ctrl.aluOp = aluAdd;
		ctrl.wbSel = wbAlu;
		ctrl.pcSel = pcStep;
		imm = '0;
		case (opcode)
			opReg: begin
				ctrl.regWrite = 1'b1;
				case (funct3)
					3'b000: ctrl.aluOp = funct7[5] ? aluSub : aluAdd;
					3'b001: ctrl.aluOp = aluSll;
					3'b010: ctrl.aluOp = aluSlt;
					3'b011: ctrl.aluOp = aluSltu;
					3'b100: ctrl.aluOp = aluXor;
					3'b101: ctrl.aluOp = funct7[5] ? aluSra : aluSrl;
					3'b110: ctrl.aluOp = aluOr;
					default: ctrl.aluOp = aluAnd;
				endcase
				// Only SUB and SRA take the alternate funct7
				if (funct7 == 7'b0100000) begin
					if (funct3 != 3'b000 && funct3 != 3'b101)
						ctrl.illegal = 1'b1;
				end else if (funct7 != 7'b0000000) begin
					ctrl.illegal = 1'b1;
				end
			end
			opImm: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				imm = immI;
				case (funct3)
					3'b000: ctrl.aluOp = aluAdd;
					3'b010: ctrl.aluOp = aluSlt;
					3'b011: ctrl.aluOp = aluSltu;
					3'b100: ctrl.aluOp = aluXor;
					3'b110: ctrl.aluOp = aluOr;
					3'b111: ctrl.aluOp = aluAnd;
					3'b001: begin
						ctrl.aluOp = aluSll;
						if (funct7 != 7'b0000000)
							ctrl.illegal = 1'b1;
					end
					default: begin
						case (funct7)
							7'b0000000: ctrl.aluOp = aluSrl;
							7'b0100000: ctrl.aluOp = aluSra;
							default: ctrl.illegal = 1'b1;
						endcase
					end
				endcase
			end
			opLui: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluOp = aluPassB;
				imm = immU;
			end
			opAuipc: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.srcA = srcPc;
				imm = immU;
			end
			opLoad: begin
				ctrl.regWrite = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.wbSel = wbMem;
				imm = immI;
				// Word access only
				if (funct3 != 3'b010)
					ctrl.illegal = 1'b1;
			end
			opStore: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				imm = immS;
				if (funct3 != 3'b010)
					ctrl.illegal = 1'b1;
			end
			opJal: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.srcA = srcPc;
				ctrl.wbSel = wbLink;
				ctrl.pcSel = pcJal;
				imm = immJ;
			end
			opJalr: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.wbSel = wbLink;
				ctrl.pcSel = pcJalr;
				imm = immI;
				if (funct3 != 3'b000)
					ctrl.illegal = 1'b1;
			end
			opBranch: begin
				ctrl.pcSel = pcBranch;
				imm = immB;
				case (funct3)
					3'b000: ctrl.aluOp = aluEq;
					3'b001: ctrl.aluOp = aluNe;
					3'b100: ctrl.aluOp = aluLt;
					3'b101: ctrl.aluOp = aluGe;
					3'b110: ctrl.aluOp = aluLtu;
					3'b111: ctrl.aluOp = aluGeu;
					default: ctrl.illegal = 1'b1;
				endcase
			end
			default: ctrl.illegal = 1'b1;
		endcase
		// Illegal words retire as a plain step
		if (ctrl.illegal) begin
			ctrl.regWrite = 1'b0;
			ctrl.memRead = 1'b0;
			ctrl.memWrite = 1'b0;
			ctrl.pcSel = pcStep;
		end
	end

endmodule

`default_nettype wire

/* logic/aluUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module aluUnit import coreDefs::*; (
	input  logic [31:0] a,
	input  logic [31:0] b,
	input  aluOpT       op,
	output logic [31:0] result,
	output logic        taken
);

	logic [4:0] shamt;
	logic       signedLt;
	logic       unsignedLt;

	assign shamt = b[4:0];
	assign signedLt = $signed(a) < $signed(b);
	assign unsignedLt = a < b;

	always_comb begin
		result = '0;
		taken = 1'b0;
		case (op)
			aluAdd:   result = a + b;
			aluSub:   result = a - b;
			aluAnd:   result = a & b;
			aluOr:    result = a | b;
			aluXor:   result = a ^ b;
			aluSll:   result = a << shamt;
			aluSrl:   result = a >> shamt;
			aluSra:   result = $signed(a) >>> shamt;
			aluPassB: result = b;
			aluSlt: begin
				taken = signedLt;
				result = {31'b0, signedLt};
			end
			aluSltu: begin
				taken = unsignedLt;
				result = {31'b0, unsignedLt};
			end
			// Branch compares only raise taken
			aluEq:  taken = (a == b);
			aluNe:  taken = (a != b);
			aluLt:  taken = signedLt;
			aluGe:  taken = !signedLt;
			aluLtu: taken = unsignedLt;
			aluGeu: taken = !unsignedLt;
			default: result = '0;
		endcase
	end

endmodule

`default_nettype wire

/* logic/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile (
	input  logic        clk,
	input  logic        rstN,
	input  logic [4:0]  rs1,
	input  logic [4:0]  rs2,
	output logic [31:0] rd1,
	output logic [31:0] rd2,
	input  logic        we,
	input  logic [4:0]  rd,
	input  logic [31:0] wd
);

	logic [31:0] regs [32];

	assign rd1 = regs[rs1];
	assign rd2 = regs[rs2];

	// x0 is never written, so it keeps its reset value
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (we && rd != 5'd0) begin
			regs[rd] <= wd;
		end
	end

	x0ReadsZero: assert property (@(posedge clk) disable iff (!rstN)
		((rs1 == 5'd0) |-> (rd1 == '0)) and ((rs2 == 5'd0) |-> (rd2 == '0)));

endmodule

`default_nettype wire

/* logic/pcUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module pcUnit import coreDefs::*; #(
	parameter logic [31:0] resetPc = 32'h0
) (
	input  logic        clk,
	input  logic        rstN,
	input  logic        update,
	input  pcSelT       pcSel,
	input  logic        taken,
	input  logic [31:0] target,
	output logic [31:0] pc,
	output logic [31:0] nextPc
);

	logic [31:0] stepPc;

	assign stepPc = pc + 32'd4;

	always_comb begin
		case (pcSel)
			pcBranch: nextPc = taken ? target : stepPc;
			pcJal:    nextPc = target;
			// JALR drops bit zero of the sum
			pcJalr:   nextPc = {target[31:1], 1'b0};
			default:  nextPc = stepPc;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			pc <= resetPc;
		else if (update)
			pc <= nextPc;
	end

	pcAligned: assert property (@(posedge clk) disable iff (!rstN)
		pc[1:0] == 2'b00);

endmodule

`default_nettype wire

/* logic/coreSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module coreSequencer import coreDefs::*; (
	input  logic     clk,
	input  logic     rstN,
	input  ctrlT     ctrl,
	output seqStateT state,
	output logic     irLoad,
	output logic     resLoad,
	output logic     memStrobe,
	output logic     wbStrobe
);

	seqStateT nextState;

	always_comb begin
		case (state)
			stFetch: nextState = stExec;
			// Only loads and stores visit stMem
			stExec:  nextState = (ctrl.memRead || ctrl.memWrite) ? stMem : stWb;
			stMem:   nextState = stWb;
			default: nextState = stFetch;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			state <= stFetch;
		else
			state <= nextState;
	end

	assign irLoad = (state == stFetch);
	assign resLoad = (state == stExec);
	assign memStrobe = (state == stMem);
	assign wbStrobe = (state == stWb);

	memOnlyAfterExec: assert property (@(posedge clk) disable iff (!rstN)
		memStrobe |-> $past(state == stExec) && (ctrl.memRead || ctrl.memWrite));

	wbSingleCycle: assert property (@(posedge clk) disable iff (!rstN)
		wbStrobe |=> !wbStrobe);

	fetchOnlyAfterWb: assert property (@(posedge clk) disable iff (!rstN)
		(state != stWb) |=> (state != stFetch));

endmodule

`default_nettype wire

/* logic/coreTop.sv */
`timescale 1ns/1ps
`default_nettype none

module coreTop import coreDefs::*; #(
	parameter logic [31:0] resetPc = 32'h0
) (
	input  logic        clk,
	input  logic        rstN,
	output logic [31:0] imemAddr,
	input  logic [31:0] imemData,
	output memReqT      dmemReq,
	input  logic [31:0] dmemRdata,
	output traceT       retire
);

	seqStateT    state;
	logic        irLoad;
	logic        resLoad;
	logic        memStrobe;
	logic        wbStrobe;
	ctrlT        ctrl;
	logic [31:0] imm;
	logic [31:0] pc;
	logic [31:0] nextPc;
	logic [31:0] target;
	logic [31:0] rd1;
	logic [31:0] rd2;
	logic [31:0] opA;
	logic [31:0] opB;
	logic [31:0] aluResult;
	logic        aluTaken;
	logic [31:0] irReg;
	logic [31:0] resReg;
	logic        takenReg;
	logic [31:0] storeData;
	logic [31:0] loadData;
	logic [31:0] wbData;
	logic        regWe;

	coreSequencer seq0 (
		.clk(clk), .rstN(rstN), .ctrl(ctrl), .state(state), .irLoad(irLoad),
		.resLoad(resLoad), .memStrobe(memStrobe), .wbStrobe(wbStrobe)
	);

	pcUnit #(.resetPc(resetPc)) pc0 (
		.clk(clk), .rstN(rstN), .update(wbStrobe), .pcSel(ctrl.pcSel),
		.taken(takenReg), .target(target), .pc(pc), .nextPc(nextPc)
	);

	instrDecoder dec0 (.instr(irReg), .ctrl(ctrl), .imm(imm));

	regFile rf0 (
		.clk(clk), .rstN(rstN), .rs1(irReg[19:15]), .rs2(irReg[24:20]),
		.rd1(rd1), .rd2(rd2), .we(regWe), .rd(irReg[11:7]), .wd(wbData)
	);

	aluUnit alu0 (.a(opA), .b(opB), .op(ctrl.aluOp), .result(aluResult), .taken(aluTaken));

	assign imemAddr = pc;
	assign opA = (ctrl.srcA == srcPc) ? pc : rd1;
	assign opB = ctrl.aluSrcImm ? imm : rd2;

	// Jumps take their target from the ALU, branches add the offset here
	assign target = (ctrl.pcSel == pcBranch) ? (pc + imm) : resReg;

	always_ff @(posedge clk) begin
		if (irLoad)
			irReg <= imemData;
		if (resLoad) begin
			resReg <= aluResult;
			takenReg <= aluTaken;
			storeData <= rd2;
		end
		if (memStrobe && ctrl.memRead)
			loadData <= dmemRdata;
	end

	assign dmemReq.addr = {resReg[31:2], 2'b00};
	assign dmemReq.wdata = storeData;
	assign dmemReq.re = memStrobe && ctrl.memRead;
	assign dmemReq.we = memStrobe && ctrl.memWrite;

	always_comb begin
		case (ctrl.wbSel)
			wbMem:   wbData = loadData;
			wbLink:  wbData = pc + 32'd4;
			default: wbData = resReg;
		endcase
	end

	assign regWe = wbStrobe && ctrl.regWrite;

	assign retire.valid = wbStrobe;
	assign retire.pc = pc;
	assign retire.instr = irReg;
	assign retire.rdWrite = ctrl.regWrite && (irReg[11:7] != 5'd0);
	assign retire.rdAddr = irReg[11:7];
	assign retire.rdData = wbData;
	assign retire.nextPc = nextPc;

	oneMemStrobe: assert property (@(posedge clk) disable iff (!rstN)
		(state == stMem) |-> (dmemReq.re ^ dmemReq.we));

endmodule

`default_nettype wire

/* sim/clockGen.sv */
`timescale 1ns/1ps
`default_nettype none

module clockGen (
	output logic clk,
	output logic rstN
);

	// 20 ns period
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Reset held low for five rising edges
	initial begin
		rstN = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		rstN = 1'b1;
	end

endmodule

`default_nettype wire

/* sim/coreTb.sv */
`timescale 1ns/1ps
`default_nettype none

module coreTb import coreDefs::*; ();

	localparam logic [31:0] resetPc = 32'h0;
	localparam int numRetire = 2000;
	localparam int timeoutCycles = numRetire * 4 + 100;
	localparam int numCats = 6;
	localparam int catReset = 0;
	localparam int catArith = 1;
	localparam int catMem = 2;
	localparam int catFlow = 3;
	localparam int catIllegal = 4;
	localparam int catSpacing = 5;

	logic        clk;
	logic        rstN;
	logic [31:0] imemAddr;
	logic [31:0] imemData;
	memReqT      dmemReq;
	logic [31:0] dmemRdata;
	traceT       retire;

	logic [31:0] imemWords [1024];
	logic        imemValid [1024];
	logic [31:0] dataMem [1024];
	logic [31:0] modelMem [1024];
	logic [31:0] modelRegs [32];
	logic [31:0] modelPc;
	string       catName [numCats];
	int          checks [numCats];
	int          fails [numCats];
	int          cycleIdx;
	int          runCycles;
	int          retired;
	int          lastRetireCycle;
	bit          resetEndChecked;
	int          weCount;
	int          reCount;
	logic [31:0] weAddr;
	logic [31:0] weData;
	bit          wrPending;

	clockGen clk0 (.clk(clk), .rstN(rstN));

	coreTop #(.resetPc(resetPc)) dut0 (
		.clk(clk), .rstN(rstN), .imemAddr(imemAddr), .imemData(imemData),
		.dmemReq(dmemReq), .dmemRdata(dmemRdata), .retire(retire)
	);

	task automatic logError(input int cat, input string msg);
		fails[cat]++;
		$display("ERROR %0t: %s", $time, msg);
	endtask

	function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
			input logic [31:0] a, input logic [31:0] b);
		logic [31:0] sraVal;
		sraVal = $signed(a) >>> b[4:0];
		case (f3)
			3'b000: return alt ? a - b : a + b;
			3'b001: return a << b[4:0];
			3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b011: return (a < b) ? 32'd1 : 32'd0;
			3'b100: return a ^ b;
			3'b101: return alt ? sraVal : a >> b[4:0];
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branchRef(input logic [2:0] f3, input logic [31:0] a,
			input logic [31:0] b);
		case (f3)
			3'b000: return a == b;
			3'b001: return a != b;
			3'b100: return $signed(a) < $signed(b);
			3'b101: return $signed(a) >= $signed(b);
			3'b110: return a < b;
			default: return a >= b;
		endcase
	endfunction

	function automatic logic [31:0] genInstr(input logic [31:0] addr);
		logic [31:0] r;
		logic [31:0] off;
		logic [11:0] imm;
		logic [6:0]  f7;
		logic [2:0]  f3;
		int          roll;
		r = $urandom();
		imm = r[31:20];
		f3 = r[14:12];
		// Jump and branch targets land anywhere in the 4 KB window
		off = resetPc + ($urandom_range(1023, 0) << 2) - addr;
		roll = $urandom_range(99, 0);
		if (addr[11:2] == 10'h3ff)
			roll = 93;
		if (roll < 5)
			return {r[31:2], r[1], 1'b0};
		if (roll < 30) begin
			f7 = ((f3 == 3'b000 || f3 == 3'b101) && r[30]) ? 7'h20 : 7'h00;
			return {f7, r[24:20], r[19:15], f3, r[11:7], 7'b0110011};
		end
		if (roll < 48) begin
			if (f3 == 3'b001)
				imm[11:5] = 7'h00;
			else if (f3 == 3'b101)
				imm[11:5] = r[25] ? 7'h20 : 7'h00;
			return {imm, r[19:15], f3, r[11:7], 7'b0010011};
		end
		if (roll < 54)
			return {r[31:12], r[11:7], 7'b0110111};
		if (roll < 60)
			return {r[31:12], r[11:7], 7'b0010111};
		if (roll < 70)
			return {imm, r[19:15], 3'b010, r[11:7], 7'b0000011};
		if (roll < 80)
			return {imm[11:5], r[24:20], r[19:15], 3'b010, imm[4:0], 7'b0100011};
		if (roll < 90) begin
			if (f3[2:1] == 2'b01)
				f3[2] = 1'b1;
			return {off[12], off[10:5], r[24:20], r[19:15], f3, off[4:1], off[11],
				7'b1100011};
		end
		if (roll < 96)
			return {off[20], off[10:1], off[11], off[19:12], r[11:7], 7'b1101111};
		// JALR from x0, bit zero sometimes set
		imm = {1'b0, r[29:21], 1'b0, r[20]};
		return {imm, 5'd0, 3'b000, r[11:7], 7'b1100111};
	endfunction

	task automatic driveMemory();
		logic [9:0] idx;
		if (wrPending)
			dataMem[weAddr[11:2]] = weData;
		wrPending = 1'b0;
		idx = imemAddr[11:2];
		if (imemAddr[31:12] != resetPc[31:12] || imemAddr[1:0] != 2'b00)
			logError(catFlow, $sformatf("fetch at %h outside the program window", imemAddr));
		if (!imemValid[idx]) begin
			imemWords[idx] = genInstr(imemAddr);
			imemValid[idx] = 1'b1;
		end
		imemData = imemWords[idx];
		dmemRdata = (dmemReq.re === 1'b1) ? dataMem[dmemReq.addr[11:2]] : 32'h0;
	endtask

	task automatic checkQuiet();
		checks[catReset]++;
		if (dmemReq.re !== 1'b0 || dmemReq.we !== 1'b0 || retire.valid !== 1'b0)
			logError(catReset, "memory strobe or retire active around reset");
	endtask

	task automatic checkRetire();
		logic [31:0] ins;
		logic [6:0]  opc;
		logic [2:0]  f3;
		logic [4:0]  rd;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] immI;
		logic [31:0] addr;
		logic [31:0] expData;
		logic [31:0] expNext;
		logic        wr;
		logic        legal;
		logic        isLoad;
		logic        isStore;
		logic        expW;
		int          cat;
		ins = retire.instr;
		opc = ins[6:0];
		f3 = ins[14:12];
		rd = ins[11:7];
		a = modelRegs[ins[19:15]];
		b = modelRegs[ins[24:20]];
		immI = {{20{ins[31]}}, ins[31:20]};
		addr = '0;
		expData = '0;
		expNext = modelPc + 32'd4;
		wr = 1'b0;
		legal = 1'b1;
		isLoad = 1'b0;
		isStore = 1'b0;
		cat = catArith;
		checks[catFlow]++;
		if (retire.pc !== modelPc || ins !== imemWords[modelPc[11:2]])
			logError(catFlow, $sformatf("retired pc %h instr %h, expected pc %h instr %h",
				retire.pc, ins, modelPc, imemWords[modelPc[11:2]]));
		if (retired == 0) begin
			checks[catReset]++;
			if (retire.pc !== resetPc)
				logError(catReset, $sformatf("first retire pc %h, expected %h", retire.pc, resetPc));
			$display("Reset: %0d checks, %0d errors", checks[catReset], fails[catReset]);
		end
		case (opc)
			7'b0110011: begin
				legal = ins[31:25] == 7'h00 ||
					(ins[31:25] == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
				wr = 1'b1;
				expData = aluRef(f3, ins[30], a, b);
			end
			7'b0010011: begin
				if (f3 == 3'b001)
					legal = ins[31:25] == 7'h00;
				else if (f3 == 3'b101)
					legal = ins[31:25] == 7'h00 || ins[31:25] == 7'h20;
				wr = 1'b1;
				expData = aluRef(f3, f3 == 3'b101 && ins[30], a, immI);
			end
			7'b0110111: begin
				wr = 1'b1;
				expData = {ins[31:12], 12'b0};
			end
			7'b0010111: begin
				wr = 1'b1;
				expData = modelPc + {ins[31:12], 12'b0};
			end
			7'b0000011: begin
				legal = f3 == 3'b010;
				cat = catMem;
				wr = 1'b1;
				isLoad = 1'b1;
				addr = a + immI;
				expData = modelMem[addr[11:2]];
			end
			7'b0100011: begin
				legal = f3 == 3'b010;
				cat = catMem;
				isStore = 1'b1;
				addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
			end
			7'b1101111: begin
				cat = catFlow;
				wr = 1'b1;
				expData = modelPc + 32'd4;
				expNext = modelPc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
			end
			7'b1100111: begin
				legal = f3 == 3'b000;
				cat = catFlow;
				wr = 1'b1;
				expData = modelPc + 32'd4;
				expNext = (a + immI) & ~32'd1;
			end
			7'b1100011: begin
				legal = f3 != 3'b010 && f3 != 3'b011;
				cat = catFlow;
				if (branchRef(f3, a, b))
					expNext = modelPc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
			end
			default: legal = 1'b0;
		endcase
		if (!legal) begin
			cat = catIllegal;
			wr = 1'b0;
			isLoad = 1'b0;
			isStore = 1'b0;
			expNext = modelPc + 32'd4;
		end
		// x0 writes must not show up as register writes
		expW = wr && (rd != 5'd0);
		checks[cat]++;
		if (retire.rdWrite !== expW)
			logError(cat, $sformatf("pc %h rdWrite %b, expected %b", modelPc, retire.rdWrite, expW));
		if (expW) begin
			checks[cat]++;
			if (retire.rdAddr !== rd || retire.rdData !== expData)
				logError(cat, $sformatf("pc %h wrote x%0d = %h, expected x%0d = %h", modelPc,
					retire.rdAddr, retire.rdData, rd, expData));
		end
		checks[cat]++;
		if (retire.nextPc !== expNext)
			logError(cat, $sformatf("pc %h nextPc %h, expected %h", modelPc, retire.nextPc, expNext));
		checks[cat]++;
		if (isStore) begin
			if (weCount != 1 || reCount != 0)
				logError(catMem, $sformatf("SW at pc %h raised we %0d times", modelPc, weCount));
			else if (weAddr !== {addr[31:2], 2'b00} || weData !== b)
				logError(catMem, $sformatf("SW wrote %h to %h, expected %h to %h", weData, weAddr,
					b, {addr[31:2], 2'b00}));
		end else if (isLoad) begin
			if (reCount != 1 || weCount != 0)
				logError(catMem, $sformatf("LW at pc %h raised re %0d times", modelPc, reCount));
		end else if (reCount != 0 || weCount != 0) begin
			logError(cat, $sformatf("memory strobe for pc %h without memory access", modelPc));
		end
		// Loads and stores spend one extra cycle in stMem
		if (retired > 0) begin
			checks[catSpacing]++;
			if (cycleIdx - lastRetireCycle != ((isLoad || isStore) ? 4 : 3))
				logError(catSpacing, $sformatf("retire spacing %0d cycles at pc %h",
					cycleIdx - lastRetireCycle, modelPc));
		end
		if (expW)
			modelRegs[rd] = expData;
		if (isStore)
			modelMem[addr[11:2]] = b;
		modelPc = expNext;
		lastRetireCycle = cycleIdx;
		weCount = 0;
		reCount = 0;
		retired++;
	endtask

	task automatic observe();
		cycleIdx++;
		if (dmemReq.we === 1'b1) begin
			weCount++;
			weAddr = dmemReq.addr;
			weData = dmemReq.wdata;
			wrPending = 1'b1;
		end
		if (dmemReq.re === 1'b1)
			reCount++;
		if (retire.valid === 1'b1)
			checkRetire();
	endtask

	always @(posedge clk) begin
		if (rstN) begin
			runCycles++;
			if (runCycles > timeoutCycles) begin
				$display("Timeout: core stopped retiring instructions after %0d cycles", runCycles);
				$display("Simulation finished: FAIL");
				$finish;
			end
		end
	end

	initial begin
		int totalPass;
		int totalFail;
		void'($urandom(11706));
		imemData = '0;
		dmemRdata = '0;
		catName = '{"Reset", "Arithmetic", "Memory", "Control flow", "Illegal words",
			"Retire spacing"};
		for (int i = 0; i < 1024; i++) begin
			imemValid[i] = 1'b0;
			dataMem[i] = '0;
			modelMem[i] = '0;
		end
		for (int i = 0; i < 32; i++)
			modelRegs[i] = '0;
		modelPc = resetPc;
		while (retired < numRetire) begin
			@(posedge clk);
			#1;
			driveMemory();
			@(negedge clk);
			if (!rstN) begin
				checkQuiet();
			end else begin
				if (!resetEndChecked)
					checkQuiet();
				resetEndChecked = 1'b1;
				observe();
			end
		end
		totalPass = 0;
		totalFail = 0;
		for (int c = 0; c < numCats; c++) begin
			if (c != catReset)
				$display("%s: %0d checks, %0d errors", catName[c], checks[c], fails[c]);
			totalPass += checks[c] - fails[c];
			totalFail += fails[c];
		end
		$display("Checks passed: %0d, failed: %0d", totalPass, totalFail);
		if (totalFail == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
logic/coreDefs.sv
logic/instrDecoder.sv
logic/aluUnit.sv
logic/regFile.sv
logic/pcUnit.sv
logic/coreSequencer.sv
logic/coreTop.sv
sim/clockGen.sv
sim/coreTb.sv
